// File: hps_fifo_bridge.f
verilog/hps_fifo_bridge_pkg.sv
verilog/command_decoder.sv
verilog/spike_fetch.sv
verilog/echo_channel.sv
verilog/hps_fifo_bridge_top.sv
verification/fifo_source_model.sv
verification/hps_fifo_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns \
	-f hps_fifo_bridge.f --top-module hps_fifo_bridge_tb -Mdir obj_dir \
	&& ./obj_dir/Vhps_fifo_bridge_tb > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "All tests passed" sim.log \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

// File: verification/fifo_source_model.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_source_model
	import hps_fifo_bridge_pkg::*;
(
	input logic CLOCK_50,
	input logic rst,
	input logic push,
	input word_t push_data,
	input logic read,
	output logic empty,
	output word_t data
);

	// Stored words, oldest first
	word_t words[$];

	// Defined levels before the first clock edge
	initial
	begin
		empty <= 1'b1;
		data <= '0;
	end

	// Read pulse shows the next word in the following cycle
	always @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			words.delete();
			data <= '0;
			empty <= 1'b1;
		end
		else
		begin
			if (read && (words.size() > 0))
				data <= words.pop_front();
			if (push)
				words.push_back(push_data);
			empty <= (words.size() == 0);
		end
	end

endmodule

`default_nettype wire

// File: verification/hps_fifo_bridge_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hps_fifo_bridge_tb
	import hps_fifo_bridge_pkg::*;
();

	// ========================================
	// Run sizes and limits
	// ========================================
	localparam int N_ENTRIES = 8;
	localparam int N_ECHO = 16;
	localparam int IDLE_CYCLES = 8;
	localparam int DRAIN_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = N_ENTRIES * 20 + N_ECHO * 8 + 50;
	localparam int DRIVE_DELAY = 1;

	// One command with its spike pair
	typedef struct {
		word_t code;
		word_t spike0;
		word_t spike1;
		logic result;
	} stim_entry_t;

	logic CLOCK_50;
	logic rst;

	// Host side of the source FIFO models
	logic cmd_push, spike0_push, spike1_push, echo_push;
	word_t cmd_push_data, spike0_push_data, spike1_push_data, echo_push_data;

	// DUT ports
	logic cmd_empty, cmd_read, spike0_read, spike1_read, result_write;
	logic echo_in_empty, echo_in_read, echo_out_write;
	logic spike0_empty, spike1_empty;
	word_t cmd_data, spike0_data, spike1_data, result_data, echo_in_data, echo_out_data;

	stim_entry_t stim [N_ENTRIES];
	word_t exp_results[$];
	int exp_result_idx[$];
	word_t exp_echo[$];
	int echo_sent;
	int echo_seen;
	int cycle_count;
	integer seed;

	hps_fifo_bridge_top DUT (
		.CLOCK_50 (CLOCK_50), .rst (rst),
		.cmd_empty (cmd_empty), .cmd_data (cmd_data), .cmd_read (cmd_read),
		.spike0_data (spike0_data), .spike0_read (spike0_read),
		.spike1_data (spike1_data), .spike1_read (spike1_read),
		.result_write (result_write), .result_data (result_data),
		.echo_in_empty (echo_in_empty), .echo_in_data (echo_in_data),
		.echo_in_read (echo_in_read), .echo_out_write (echo_out_write),
		.echo_out_data (echo_out_data)
	);

	fifo_source_model cmd_fifo (.CLOCK_50 (CLOCK_50), .rst (rst), .push (cmd_push),
		.push_data (cmd_push_data), .read (cmd_read), .empty (cmd_empty), .data (cmd_data));
	fifo_source_model spike0_fifo (.CLOCK_50 (CLOCK_50), .rst (rst), .push (spike0_push),
		.push_data (spike0_push_data), .read (spike0_read), .empty (spike0_empty),
		.data (spike0_data));
	fifo_source_model spike1_fifo (.CLOCK_50 (CLOCK_50), .rst (rst), .push (spike1_push),
		.push_data (spike1_push_data), .read (spike1_read), .empty (spike1_empty),
		.data (spike1_data));
	fifo_source_model echo_fifo (.CLOCK_50 (CLOCK_50), .rst (rst), .push (echo_push),
		.push_data (echo_push_data), .read (echo_in_read), .empty (echo_in_empty),
		.data (echo_in_data));

	// 100 ns period
	always #50 CLOCK_50 = ~CLOCK_50;

	// ========================================
	// Checks and failure exit
	// ========================================
	task automatic end_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %b actual %b", name, expected, actual);
			end_with_failure();
		end
	endtask

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge CLOCK_50);
		#DRIVE_DELAY;
	endtask

	// One random echo word per call until all are sent
	task automatic push_echo_word();
		word_t w;
		if (echo_sent < N_ECHO)
		begin
			w = $random(seed);
			echo_push = 1'b1;
			echo_push_data = w;
			exp_echo.push_back(w);
			echo_sent++;
		end
		else
			echo_push = 1'b0;
	endtask

	// ========================================
	// Sink monitors, sampled mid-cycle
	// ========================================
	always @(negedge CLOCK_50)
	begin : result_monitor
		string name;
		if (!rst && result_write)
		begin
			if (exp_results.size() == 0)
			begin
				$display("Result write with no sum command pending, data %h", result_data);
				end_with_failure();
			end
			else
			begin
				name = $sformatf("result of entry %0d", exp_result_idx.pop_front());
				check_word(name, exp_results.pop_front(), result_data);
			end
		end
	end

	always @(negedge CLOCK_50)
	begin : echo_monitor
		string name;
		if (!rst && echo_out_write)
		begin
			if (exp_echo.size() == 0)
			begin
				$display("Echo write with no word left to echo, data %h", echo_out_data);
				end_with_failure();
			end
			else
			begin
				name = $sformatf("echo word %0d", echo_seen);
				check_word(name, exp_echo.pop_front(), echo_out_data);
				echo_seen++;
			end
		end
	end

	// Run limit
	always @(posedge CLOCK_50)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the DUT did not finish its writes", cycle_count);
			end_with_failure();
		end
	end

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin : main_sequence
		word_t sum;
		CLOCK_50 = 1'b0;
		rst = 1'b1;
		{cmd_push, spike0_push, spike1_push, echo_push} = '0;
		{cmd_push_data, spike0_push_data, spike1_push_data, echo_push_data} = '0;
		echo_sent = 0;
		echo_seen = 0;
		cycle_count = 0;
		seed = 32'h38c47e52;

		// Sum codes, wrap-around pairs and unknown codes
		stim[0] = '{CMD_SUM, 32'h00000005, 32'h00000007, 1'b1};
		stim[1] = '{CMD_SUM, 32'h12345678, 32'h11111111, 1'b1};
		stim[2] = '{CMD_SUM, 32'hffffffff, 32'h00000001, 1'b1};
		stim[3] = '{32'd7, 32'haaaaaaaa, 32'h55555555, 1'b0};
		stim[4] = '{CMD_SUM, 32'h80000000, 32'h80000001, 1'b1};
		stim[5] = '{32'd0, 32'hdeadbeef, 32'h00000000, 1'b0};
		stim[6] = '{CMD_SUM, 32'hfffffff0, 32'h00000020, 1'b1};
		stim[7] = '{CMD_SUM, 32'h0badf00d, 32'h00c0ffee, 1'b1};

		repeat (3) @(posedge CLOCK_50);
		#DRIVE_DELAY;
		rst = 1'b0;

		// All FIFOs empty, every strobe low
		repeat (IDLE_CYCLES)
		begin
			@(negedge CLOCK_50);
			check_flag("idle cmd_read", 1'b0, cmd_read);
			check_flag("idle spike0_read", 1'b0, spike0_read);
			check_flag("idle spike1_read", 1'b0, spike1_read);
			check_flag("idle result_write", 1'b0, result_write);
			check_flag("idle echo_in_read", 1'b0, echo_in_read);
			check_flag("idle echo_out_write", 1'b0, echo_out_write);
		end
		next_cycle();

		// Fetch plus entry code, with echo words loaded alongside
		for (int i = 0; i < N_ENTRIES; i++)
		begin
			cmd_push = 1'b1;
			cmd_push_data = CMD_FETCH;
			spike0_push = 1'b1;
			spike0_push_data = stim[i].spike0;
			spike1_push = 1'b1;
			spike1_push_data = stim[i].spike1;
			if (stim[i].result)
			begin
				sum = stim[i].spike0 + stim[i].spike1;
				exp_results.push_back(sum);
				exp_result_idx.push_back(i);
			end
			push_echo_word();
			next_cycle();
			cmd_push_data = stim[i].code;
			spike0_push = 1'b0;
			spike1_push = 1'b0;
			push_echo_word();
			next_cycle();
		end
		cmd_push = 1'b0;

		// Remaining echo words
		while (echo_sent < N_ECHO)
		begin
			push_echo_word();
			next_cycle();
		end
		echo_push = 1'b0;

		// Wait for every expected write, the run limit guards this
		while ((exp_results.size() != 0) || (exp_echo.size() != 0))
			@(posedge CLOCK_50);

		// Catch stray writes and leftover commands
		repeat (DRAIN_CYCLES) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		check_flag("command FIFO drained", 1'b1, cmd_empty);
		check_flag("echo input FIFO drained", 1'b1, echo_in_empty);
		check_flag("spike FIFO 0 drained", 1'b1, spike0_empty);
		check_flag("spike FIFO 1 drained", 1'b1, spike1_empty);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/command_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module command_decoder
	import hps_fifo_bridge_pkg::*;
(
	input logic CLOCK_50,
	input logic rst,
	input logic cmd_empty,
	input word_t cmd_data,
	input logic fetch_done,
	output logic cmd_read,
	output logic fetch_start,
	output logic result_write
);

	cmd_state_t state;
	cmd_state_t state_next;

	// Command word held for decode
	word_t cmd_buffer;
	logic load_cmd;

	// Set in DECODE for a sum command, high for the single WAIT cycle
	logic sum_pending;

	// Compare against the package codes
	logic is_fetch;
	logic is_sum;

	assign is_fetch = (cmd_buffer == CMD_FETCH);
	assign is_sum = (cmd_buffer == CMD_SUM);

	// ========================================
	// State register
	// ========================================
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			state <= CMD_IDLE;
		else
			state <= state_next;
	end

	// ========================================
	// Next state and strobes
	// ========================================
	always_comb
	begin
		state_next = state;
		cmd_read = 1'b0;
		load_cmd = 1'b0;
		fetch_start = 1'b0;
		case (state)
			CMD_IDLE:
			begin
				// Wait for a word in the command FIFO
				if (!cmd_empty)
					state_next = CMD_READ;
			end
			CMD_READ:
			begin
				// One-cycle read pulse
				cmd_read = 1'b1;
				state_next = CMD_LOAD;
			end
			CMD_LOAD:
			begin
				// FIFO data valid now
				load_cmd = 1'b1;
				state_next = CMD_DECODE;
			end
			CMD_DECODE:
			begin
				if (is_fetch)
				begin
					fetch_start = 1'b1;
					state_next = CMD_WAIT;
				end
				else if (is_sum)
					state_next = CMD_WAIT;
				else
					// Unknown code is simply dropped
					state_next = CMD_IDLE;
			end
			CMD_WAIT:
			begin
				// Fetch completion or the pending sum write ends the wait
				if (fetch_done || sum_pending)
					state_next = CMD_IDLE;
			end
			default:
				state_next = CMD_IDLE;
		endcase
	end

	// Command buffer
	always_ff @(posedge CLOCK_50)
	begin
		if (load_cmd)
			cmd_buffer <= cmd_data;
	end

	// Delayed sum request
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			sum_pending <= 1'b0;
		else
			sum_pending <= (state == CMD_DECODE) && is_sum;
	end

	// Result write lands in the WAIT cycle
	assign result_write = sum_pending;

endmodule

`default_nettype wire

// File: verilog/echo_channel.sv
`timescale 1ns/1ns
`default_nettype none

module echo_channel
	import hps_fifo_bridge_pkg::*;
(
	input logic CLOCK_50,
	input logic rst,
	input logic echo_in_empty,
	input word_t echo_in_data,
	output logic echo_in_read,
	output logic echo_out_write,
	output word_t echo_out_data
);

	echo_rd_state_t rd_state;
	echo_rd_state_t rd_state_next;
	echo_wr_state_t wr_state;
	echo_wr_state_t wr_state_next;

	// Reader to writer handshake
	logic load_word;
	logic wr_start;
	logic wr_ready;

	// Word in flight
	word_t word_buf;

	// ========================================
	// State registers
	// ========================================
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			rd_state <= ERD_IDLE;
			wr_state <= EWR_READY;
		end
		else
		begin
			rd_state <= rd_state_next;
			wr_state <= wr_state_next;
		end
	end

	// ========================================
	// Reader
	// ========================================
	always_comb
	begin
		rd_state_next = rd_state;
		echo_in_read = 1'b0;
		load_word = 1'b0;
		wr_start = 1'b0;
		case (rd_state)
			ERD_IDLE:
			begin
				// Only one word in flight
				if (!echo_in_empty && wr_ready)
					rd_state_next = ERD_READ;
			end
			ERD_READ:
			begin
				echo_in_read = 1'b1;
				rd_state_next = ERD_LOAD;
			end
			ERD_LOAD:
			begin
				// Capture and hand over to the writer
				load_word = 1'b1;
				wr_start = 1'b1;
				rd_state_next = ERD_IDLE;
			end
			default:
				rd_state_next = ERD_IDLE;
		endcase
	end

	// ========================================
	// Writer
	// ========================================
	always_comb
	begin
		wr_state_next = wr_state;
		wr_ready = 1'b0;
		echo_out_write = 1'b0;
		case (wr_state)
			EWR_READY:
			begin
				wr_ready = 1'b1;
				if (wr_start)
					wr_state_next = EWR_WRITE;
			end
			EWR_WRITE:
			begin
				// Single write of the buffered word
				echo_out_write = 1'b1;
				wr_state_next = EWR_READY;
			end
			default:
				wr_state_next = EWR_READY;
		endcase
	end

	// Word buffer
	always_ff @(posedge CLOCK_50)
	begin
		if (load_word)
			word_buf <= echo_in_data;
	end

	assign echo_out_data = word_buf;

endmodule

`default_nettype wire

// File: verilog/hps_fifo_bridge_pkg.sv
`default_nettype none

package hps_fifo_bridge_pkg;

	// ========================================
	// Word types
	// ========================================

	// One host FIFO word
	parameter int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// Spike buffer, FIFO 0 word in the low half and FIFO 1 word in the high half
	typedef logic [2*WORD_W-1:0] spike_pair_t;

	// ========================================
	// Command codes
	// ========================================

	// Write one result word
	parameter word_t CMD_SUM = 32'd1;
	// Start a spike fetch
	parameter word_t CMD_FETCH = 32'd2;

	// ========================================
	// State encodings
	// ========================================

	// Command FIFO reader and decoder
	typedef enum logic [2:0] {
		CMD_IDLE,
		CMD_READ,
		CMD_LOAD,
		CMD_DECODE,
		CMD_WAIT
	} cmd_state_t;

	// Spike FIFO pair fetch
	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_READ0,
		FETCH_READ1,
		FETCH_SETTLE,
		FETCH_DONE
	} fetch_state_t;

	// Echo path reader and writer
	typedef enum logic [1:0] {
		ERD_IDLE,
		ERD_READ,
		ERD_LOAD
	} echo_rd_state_t;

	typedef enum logic {
		EWR_READY,
		EWR_WRITE
	} echo_wr_state_t;

endpackage

`default_nettype wire

// File: verilog/hps_fifo_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module hps_fifo_bridge_top
	import hps_fifo_bridge_pkg::*;
(
	input logic CLOCK_50,
	input logic rst,

	// ========================================
	// Command FIFO, host to fabric
	// ========================================
	input logic cmd_empty,
	input word_t cmd_data,
	output logic cmd_read,

	// ========================================
	// Spike FIFOs, host to fabric
	// ========================================
	// Host loads both before a fetch command
	input word_t spike0_data,
	output logic spike0_read,
	input word_t spike1_data,
	output logic spike1_read,

	// ========================================
	// Result FIFO, fabric to host
	// ========================================
	output logic result_write,
	output word_t result_data,

	// ========================================
	// Echo FIFOs
	// ========================================
	input logic echo_in_empty,
	input word_t echo_in_data,
	output logic echo_in_read,
	output logic echo_out_write,
	output word_t echo_out_data
);

	// Decoder to fetch start pulse
	logic fetch_start;
	// Fetch to decoder completion pulse
	logic fetch_done;

	// Command path
	command_decoder u_command_decoder (
		.CLOCK_50     (CLOCK_50),
		.rst          (rst),
		.cmd_empty    (cmd_empty),
		.cmd_data     (cmd_data),
		.fetch_done   (fetch_done),
		.cmd_read     (cmd_read),
		.fetch_start  (fetch_start),
		.result_write (result_write)
	);

	// Spike pair fetch, sum goes straight to the result FIFO
	spike_fetch u_spike_fetch (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.fetch_start (fetch_start),
		.spike0_data (spike0_data),
		.spike1_data (spike1_data),
		.spike0_read (spike0_read),
		.spike1_read (spike1_read),
		.fetch_done  (fetch_done),
		.pair_sum    (result_data)
	);

	// Echo path runs on its own
	echo_channel u_echo_channel (
		.CLOCK_50       (CLOCK_50),
		.rst            (rst),
		.echo_in_empty  (echo_in_empty),
		.echo_in_data   (echo_in_data),
		.echo_in_read   (echo_in_read),
		.echo_out_write (echo_out_write),
		.echo_out_data  (echo_out_data)
	);

endmodule

`default_nettype wire

// File: verilog/spike_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module spike_fetch
	import hps_fifo_bridge_pkg::*;
(
	input logic CLOCK_50,
	input logic rst,
	input logic fetch_start,
	input word_t spike0_data,
	input word_t spike1_data,
	output logic spike0_read,
	output logic spike1_read,
	output logic fetch_done,
	output word_t pair_sum
);

	fetch_state_t state;
	fetch_state_t state_next;

	// Load strobes trail the read pulses by one cycle
	logic load0;
	logic load1;

	// Both spike words
	spike_pair_t spike_buf;

	// ========================================
	// State register
	// ========================================
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			state <= FETCH_IDLE;
		else
			state <= state_next;
	end

	// ========================================
	// Next state and read strobes
	// ========================================
	always_comb
	begin
		state_next = state;
		spike0_read = 1'b0;
		spike1_read = 1'b0;
		fetch_done = 1'b0;
		case (state)
			FETCH_IDLE:
			begin
				if (fetch_start)
					state_next = FETCH_READ0;
			end
			FETCH_READ0:
			begin
				// Spike FIFO 0 first
				spike0_read = 1'b1;
				state_next = FETCH_READ1;
			end
			FETCH_READ1:
			begin
				spike1_read = 1'b1;
				state_next = FETCH_SETTLE;
			end
			FETCH_SETTLE:
				// Let the second word land in the buffer
				state_next = FETCH_DONE;
			FETCH_DONE:
			begin
				fetch_done = 1'b1;
				state_next = FETCH_IDLE;
			end
			default:
				state_next = FETCH_IDLE;
		endcase
	end

	// Delayed load strobes
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			load0 <= 1'b0;
			load1 <= 1'b0;
		end
		else
		begin
			load0 <= spike0_read;
			load1 <= spike1_read;
		end
	end

	// ========================================
	// Spike buffer
	// ========================================
	always_ff @(posedge CLOCK_50)
	begin
		// Low half from FIFO 0
		if (load0)
			spike_buf[WORD_W-1:0] <= spike0_data;
		// High half from FIFO 1
		if (load1)
			spike_buf[2*WORD_W-1:WORD_W] <= spike1_data;
	end

	// Wrapping 32-bit sum of the two halves
	assign pair_sum = spike_buf[2*WORD_W-1:WORD_W] + spike_buf[WORD_W-1:0];

endmodule

`default_nettype wire
